// File: Makefile
# Verilator build and run of the APB fabric testbench
VERILATOR ?= verilator
TOP       ?= apb_soc_tb
FILELIST  ?= apb_soc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: apb_soc.f
+incdir+test
logic/apb_soc_pkg.sv
logic/apb_bus_if.sv
logic/apb_master_arbiter.sv
logic/apb_slave_decode.sv
logic/apb_response_router.sv
logic/soc_info_regs.sv
logic/gpio_out_port.sv
logic/apb_soc_top.sv
test/apb_soc_tb.sv

// File: logic/apb_bus_if.sv
/* shared APB bus after the arbiter, and the per-target select bus
   the clock on the shared bus is only there for checks in the decoder */
`timescale 1ns/1ps

interface apb_bus_if
    import apb_soc_pkg::*;
(
    input logic clk
);
    addr_t paddr;
    logic  pwrite;
    logic  psel;
    logic  penable;
    data_t pwdata;
    data_t prdata;
    logic  pready;
    logic  pslverr;

    // arbiter side
    modport initiator (output paddr, pwrite, psel, penable, pwdata,
                       input  prdata, pready, pslverr);
    // address decoder
    modport target    (input clk, paddr, pwrite, psel, penable, pwdata);
    // response router
    modport responder (input psel, penable, output prdata, pready, pslverr);
endinterface

interface apb_target_if
    import apb_soc_pkg::*;
();
    logic                  sel;
    logic                  penable;
    logic                  pwrite;
    logic [TARGET_LSB-1:0] offset;
    data_t                 pwdata;
    data_t                 prdata;
    logic                  pready;

    modport bus        (output sel, penable, pwrite, offset, pwdata, input prdata, pready);
    modport peripheral (input sel, penable, pwrite, offset, pwdata, output prdata, pready);
endinterface

// File: logic/apb_master_arbiter.sv
/* round-robin APB arbiter, one transfer on the shared bus at a time
   masters must hold psel and the request until their own pready */
`timescale 1ns/1ps

module apb_master_arbiter
    import apb_soc_pkg::*;
#(
    parameter int MASTERS = 2
) (
    input  logic                clk,
    input  logic                reset,
    input  logic  [MASTERS-1:0] m_psel,
    input  logic  [MASTERS-1:0] m_penable,
    input  logic  [MASTERS-1:0] m_pwrite,
    input  addr_t [MASTERS-1:0] m_paddr,
    input  data_t [MASTERS-1:0] m_pwdata,
    output data_t [MASTERS-1:0] m_prdata,
    output logic  [MASTERS-1:0] m_pready,
    output logic  [MASTERS-1:0] m_pslverr,
    apb_bus_if.initiator        bus
);
    localparam int IW = (MASTERS > 1) ? $clog2(MASTERS) : 1;

    typedef enum logic [1:0] {st_idle, st_setup, st_access, st_done} state_t;

    state_t             state;
    logic [MASTERS-1:0] grant;
    logic [IW-1:0]      last_idx;
    logic [MASTERS-1:0] ready_q;
    data_t              rdata_q;
    logic               slverr_q;

    logic [MASTERS-1:0] pick;
    logic [IW-1:0]      pick_idx;

    // search starts one past the last served master
    always_comb begin
        int idx;
        pick     = '0;
        pick_idx = last_idx;
        for (int k = 1; k <= MASTERS; k++) begin
            idx = (int'(last_idx) + k) % MASTERS;
            if (pick == '0 && m_psel[idx]) begin
                pick[idx] = 1'b1;
                pick_idx  = IW'(idx);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // shared bus drive
    ////////////////////////////////////////////////////////////////////

    // grant is one-hot, so and-or is enough
    always_comb begin
        bus.paddr  = '0;
        bus.pwrite = 1'b0;
        bus.pwdata = '0;
        for (int i = 0; i < MASTERS; i++) begin
            if (grant[i]) begin
                bus.paddr  = bus.paddr | m_paddr[i];
                bus.pwrite = bus.pwrite | m_pwrite[i];
                bus.pwdata = bus.pwdata | m_pwdata[i];
            end
        end
    end

    assign bus.psel    = (state == st_setup) || (state == st_access);
    assign bus.penable = (state == st_access);

    // st_done blocks arbitration while the finished master still holds psel
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            grant    <= '0;
            last_idx <= IW'(MASTERS - 1);
            ready_q  <= '0;
        end else begin
            ready_q <= '0;
            case (state)
                st_idle: begin
                    if (pick != '0) begin
                        grant    <= pick;
                        last_idx <= pick_idx;
                        state    <= st_setup;
                    end
                end
                st_setup:
                    state <= st_access;
                st_access: begin
                    if (bus.pready) begin
                        ready_q <= grant;
                        grant   <= '0;
                        state   <= st_done;
                    end
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // response capture
    always_ff @(posedge clk) begin
        if (state == st_access && bus.pready) begin
            rdata_q  <= bus.prdata;
            slverr_q <= bus.pslverr;
        end
    end

    // only the served master sees the response
    always_comb begin
        for (int i = 0; i < MASTERS; i++) begin
            m_prdata[i] = ready_q[i] ? rdata_q : '0;
        end
    end

    assign m_pready  = ready_q;
    assign m_pslverr = ready_q & {MASTERS{slverr_q}};

    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant));

    // access phase only after a setup cycle
    a_setup_first: assert property (@(posedge clk) disable iff (reset)
        $rose(bus.penable) |-> bus.psel && $past(bus.psel && !bus.penable));

    // granted master keeps its request up through the shared access phase
    a_master_holds: assert property (@(posedge clk) disable iff (reset)
        (state == st_access) |-> ((grant & m_psel & m_penable) == grant));

endmodule

// File: logic/apb_response_router.sv
/* response mux from the routed target back to the shared bus
   the error target lives here and answers in the first access cycle */
`timescale 1ns/1ps

module apb_response_router
    import apb_soc_pkg::*;
(
    apb_bus_if.responder bus,
    apb_target_if.bus    regs_t,
    apb_target_if.bus    gpio_t,
    input target_idx_t   target
);
    logic err_access;

    // error target has no state, so unmapped writes are dropped
    assign err_access = bus.psel && bus.penable;

    always_comb begin
        case (target)
            tgt_regs: begin
                bus.prdata  = regs_t.prdata;
                bus.pready  = regs_t.pready;
                bus.pslverr = 1'b0;
            end
            tgt_gpio: begin
                bus.prdata  = gpio_t.prdata;
                bus.pready  = gpio_t.pready;
                bus.pslverr = 1'b0;
            end
            default: begin
                // unmapped, read data is zero
                bus.prdata  = '0;
                bus.pready  = err_access;
                bus.pslverr = err_access;
            end
        endcase
    end

endmodule

// File: logic/apb_slave_decode.sv
/* combinational decode of the shared address into one target select
   unmapped target fields route to the error target, which has no select */
`timescale 1ns/1ps

module apb_slave_decode
    import apb_soc_pkg::*;
(
    apb_bus_if.target   bus,
    apb_target_if.bus   regs_t,
    apb_target_if.bus   gpio_t,
    output target_idx_t target
);
    logic [TARGET_WIDTH-1:0] field;

    assign field = bus.paddr[ADDR_WIDTH-1:TARGET_LSB];

    always_comb begin
        if (field == TARGET_WIDTH'(TARGET_REGS)) begin
            target = tgt_regs;
        end else if (field == TARGET_WIDTH'(TARGET_GPIO)) begin
            target = tgt_gpio;
        end else begin
            target = tgt_error;
        end
    end

    // selects
    assign regs_t.sel = bus.psel && (target == tgt_regs);
    assign gpio_t.sel = bus.psel && (target == tgt_gpio);

    // request fields go to both targets, only the selected one acts
    assign regs_t.penable = bus.penable;
    assign regs_t.pwrite  = bus.pwrite;
    assign regs_t.offset  = bus.paddr[TARGET_LSB-1:0];
    assign regs_t.pwdata  = bus.pwdata;

    assign gpio_t.penable = bus.penable;
    assign gpio_t.pwrite  = bus.pwrite;
    assign gpio_t.offset  = bus.paddr[TARGET_LSB-1:0];
    assign gpio_t.pwdata  = bus.pwdata;

    // every transfer lands on exactly one of regs, gpio or the error target
    a_one_target: assert property (@(posedge bus.clk)
        bus.psel |-> $onehot({regs_t.sel, gpio_t.sel, target == tgt_error}));

endmodule

// File: logic/apb_soc_pkg.sv
/* widths, address map and shared types for the APB fabric
   address bits from TARGET_LSB up select the target, only regs and gpio are mapped */
package apb_soc_pkg;

    // bus widths
    localparam int DATA_WIDTH = 16;
    localparam int ADDR_WIDTH = 16;

    ////////////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////////////

    // target field above, offset inside the target below
    localparam int TARGET_LSB   = 8;
    localparam int TARGET_WIDTH = ADDR_WIDTH - TARGET_LSB;

    localparam int TARGET_REGS = 0;
    localparam int TARGET_GPIO = 1;

    // real targets, reported in register 1
    localparam int NUM_TARGETS = 2;

    // size of the info register block
    localparam int REG_WORDS = 8;

    // shared types
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // routed target, error covers every unmapped field value
    typedef enum logic [1:0] {
        tgt_regs,
        tgt_gpio,
        tgt_error
    } target_idx_t;

endpackage

// File: logic/apb_soc_top.sv
/* multi-master APB fabric with info registers, gpio and an error target
   master ports are packed per master, MASTERS 1 to 4, GPIO_PINS 1 to 16 */
`timescale 1ns/1ps

module apb_soc_top
    import apb_soc_pkg::*;
#(
    parameter int MASTERS   = 2,
    parameter int GPIO_PINS = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic  [MASTERS-1:0]   m_psel,
    input  logic  [MASTERS-1:0]   m_penable,
    input  logic  [MASTERS-1:0]   m_pwrite,
    input  addr_t [MASTERS-1:0]   m_paddr,
    input  data_t [MASTERS-1:0]   m_pwdata,
    output data_t [MASTERS-1:0]   m_prdata,
    output logic  [MASTERS-1:0]   m_pready,
    output logic  [MASTERS-1:0]   m_pslverr,
    output logic  [GPIO_PINS-1:0] gpio
);
    apb_bus_if    bus (.clk(clk));
    apb_target_if regs_t ();
    apb_target_if gpio_t ();

    target_idx_t  target;

    apb_master_arbiter #(.MASTERS(MASTERS)) arbiter (
        .clk       (clk),
        .reset     (reset),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwrite  (m_pwrite),
        .m_paddr   (m_paddr),
        .m_pwdata  (m_pwdata),
        .m_prdata  (m_prdata),
        .m_pready  (m_pready),
        .m_pslverr (m_pslverr),
        .bus       (bus)
    );

    apb_slave_decode decode (.bus(bus), .regs_t(regs_t), .gpio_t(gpio_t), .target(target));

    apb_response_router router (.bus(bus), .regs_t(regs_t), .gpio_t(gpio_t), .target(target));

    // targets
    soc_info_regs #(.MASTERS(MASTERS)) regs0 (.clk(clk), .reset(reset), .t(regs_t));

    gpio_out_port #(.GPIO_PINS(GPIO_PINS)) gpio0 (
        .clk   (clk),
        .reset (reset),
        .t     (gpio_t),
        .gpio  (gpio)
    );

endmodule

// File: logic/gpio_out_port.sv
/* single output register for the gpio pins, any offset maps to it
   only the low GPIO_PINS bits of a write are kept */
`timescale 1ns/1ps

module gpio_out_port
    import apb_soc_pkg::*;
#(
    parameter int GPIO_PINS = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    apb_target_if.peripheral     t,
    output logic [GPIO_PINS-1:0] gpio
);
    logic [GPIO_PINS-1:0] pins_q;
    logic                 access;

    assign access = t.sel && t.penable;

    // pin register
    always_ff @(posedge clk) begin
        if (reset) begin
            pins_q <= '0;
        end else if (access && t.pwrite) begin
            pins_q <= t.pwdata[GPIO_PINS-1:0];
        end
    end

    assign gpio = pins_q;

    // readback, zero-extended
    assign t.prdata = data_t'(pins_q);
    assign t.pready = access;

endmodule

// File: logic/soc_info_regs.sv
/* eight-word info block, words 0 and 1 are fixed identity values
   offset wraps modulo REG_WORDS, zero wait states */
`timescale 1ns/1ps

module soc_info_regs
    import apb_soc_pkg::*;
#(
    parameter int MASTERS = 2
) (
    input  logic           clk,
    input  logic           reset,
    apb_target_if.peripheral t
);
    localparam int RW = $clog2(REG_WORDS);

    // fixed identity words
    localparam data_t ID_MASTERS = DATA_WIDTH'(MASTERS);
    localparam data_t ID_TARGETS = DATA_WIDTH'(NUM_TARGETS);

    data_t         words [2:REG_WORDS-1];
    logic [RW-1:0] idx;
    logic          access;

    assign idx    = t.offset[RW-1:0];
    assign access = t.sel && t.penable;

    ////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////

    // writes to 0 and 1 fall through
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 2; i < REG_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (access && t.pwrite && idx >= RW'(2)) begin
            words[idx] <= t.pwdata;
        end
    end

    // read side
    always_comb begin
        if (idx == RW'(0)) begin
            t.prdata = ID_MASTERS;
        end else if (idx == RW'(1)) begin
            t.prdata = ID_TARGETS;
        end else begin
            t.prdata = words[idx];
        end
    end

    // ready in the first access cycle
    assign t.pready = access;

endmodule

// File: test/apb_soc_tb_tasks.svh
/* included inside apb_soc_tb, needs clk, the master port signals and GPIO_PINS
   declared before the include, every failure stops the run at once */
`ifndef APB_SOC_TB_TASKS_SVH
`define APB_SOC_TB_TASKS_SVH

    // random write data
    logic [31:0] lcg_state = 32'd28014;

    function automatic data_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    ////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_gpio(input string name, input logic [GPIO_PINS-1:0] got,
                              input logic [GPIO_PINS-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // one APB transfer on one master port
    ////////////////////////////////////////////////////////////////////

    task automatic apb_transfer(input int m, input logic write, input addr_t addr,
                                input data_t wdata, output data_t rdata, output logic err);
        int waited;
        // setup phase
        @(negedge clk);
        m_psel[m]    = 1'b1;
        m_penable[m] = 1'b0;
        m_pwrite[m]  = write;
        m_paddr[m]   = addr;
        m_pwdata[m]  = wdata;
        // access phase, held until this master sees pready
        @(negedge clk);
        m_penable[m] = 1'b1;
        waited       = 0;
        while (m_pready[m] !== 1'b1) begin
            if (waited >= TRANSFER_TIMEOUT) begin
                stop_with_failure($sformatf(
                    "master %0d transfer to address %h never completed", m, addr));
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        rdata        = m_prdata[m];
        err          = m_pslverr[m];
        m_psel[m]    = 1'b0;
        m_penable[m] = 1'b0;
    endtask

`endif

// File: test/apb_soc_tb.sv
/* testbench for apb_soc_top with two masters and eight gpio pins
   table transfers run one at a time and the two-master contention case runs last */
`timescale 1ns/1ps

module apb_soc_tb
    import apb_soc_pkg::*;
();
    localparam int MASTERS          = 2;
    localparam int GPIO_PINS        = 8;
    localparam int TRANSFER_TIMEOUT = 20;

    localparam bit RD    = 1'b0;
    localparam bit WR    = 1'b1;
    localparam bit FIXED = 1'b0;
    localparam bit RAND  = 1'b1;

    logic                  clk;
    logic                  reset;
    logic  [MASTERS-1:0]   m_psel;
    logic  [MASTERS-1:0]   m_penable;
    logic  [MASTERS-1:0]   m_pwrite;
    addr_t [MASTERS-1:0]   m_paddr;
    data_t [MASTERS-1:0]   m_pwdata;
    data_t [MASTERS-1:0]   m_prdata;
    logic  [MASTERS-1:0]   m_pready;
    logic  [MASTERS-1:0]   m_pslverr;
    logic  [GPIO_PINS-1:0] gpio;

    // exp_rdata of a table row is ignored when rnd is set
    typedef struct {
        int    master;
        bit    write;
        bit    rnd;
        addr_t addr;
        data_t wdata;
        data_t exp_rdata;
        bit    exp_err;
    } step_t;

    step_t stim[$];

    // expected state of the targets
    data_t                reg_model [REG_WORDS];
    logic [GPIO_PINS-1:0] gpio_model;

    apb_soc_top #(.MASTERS(MASTERS), .GPIO_PINS(GPIO_PINS)) uut (
        .clk       (clk),
        .reset     (reset),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwrite  (m_pwrite),
        .m_paddr   (m_paddr),
        .m_pwdata  (m_pwdata),
        .m_prdata  (m_prdata),
        .m_pready  (m_pready),
        .m_pslverr (m_pslverr),
        .gpio      (gpio)
    );

    `include "apb_soc_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic void add_step(input int master, input bit write, input bit rnd,
                                     input addr_t addr, input data_t wdata,
                                     input data_t exp_rdata, input bit exp_err);
        step_t s;
        s.master    = master;
        s.write     = write;
        s.rnd       = rnd;
        s.addr      = addr;
        s.wdata     = wdata;
        s.exp_rdata = exp_rdata;
        s.exp_err   = exp_err;
        stim.push_back(s);
    endfunction

    ////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////

    function automatic void load_table();
        // identity words and reset values
        add_step(0, RD, FIXED, 16'h0000, 16'h0000, 16'h0002, 1'b0);
        add_step(1, RD, FIXED, 16'h0001, 16'h0000, 16'h0002, 1'b0);
        add_step(0, RD, FIXED, 16'h0002, 16'h0000, 16'h0000, 1'b0);
        add_step(1, RD, FIXED, 16'h0003, 16'h0000, 16'h0000, 1'b0);
        add_step(0, RD, FIXED, 16'h0004, 16'h0000, 16'h0000, 1'b0);
        add_step(1, RD, FIXED, 16'h0005, 16'h0000, 16'h0000, 1'b0);
        add_step(0, RD, FIXED, 16'h0006, 16'h0000, 16'h0000, 1'b0);
        add_step(1, RD, FIXED, 16'h0007, 16'h0000, 16'h0000, 1'b0);
        add_step(0, RD, FIXED, 16'h0100, 16'h0000, 16'h0000, 1'b0);
        // read/write words from both masters
        add_step(0, WR, FIXED, 16'h0002, 16'hA502, 16'h0000, 1'b0);
        add_step(1, WR, FIXED, 16'h0003, 16'h5A03, 16'h0000, 1'b0);
        add_step(0, WR, FIXED, 16'h0004, 16'hC304, 16'h0000, 1'b0);
        add_step(1, WR, FIXED, 16'h0005, 16'h3C05, 16'h0000, 1'b0);
        add_step(0, WR, FIXED, 16'h0006, 16'hF006, 16'h0000, 1'b0);
        add_step(1, WR, FIXED, 16'h0007, 16'h0FF7, 16'h0000, 1'b0);
        add_step(1, RD, FIXED, 16'h0002, 16'h0000, 16'hA502, 1'b0);
        add_step(0, RD, FIXED, 16'h0003, 16'h0000, 16'h5A03, 1'b0);
        add_step(1, RD, FIXED, 16'h0004, 16'h0000, 16'hC304, 1'b0);
        add_step(0, RD, FIXED, 16'h0005, 16'h0000, 16'h3C05, 1'b0);
        add_step(1, RD, FIXED, 16'h0006, 16'h0000, 16'hF006, 1'b0);
        add_step(0, RD, FIXED, 16'h0007, 16'h0000, 16'h0FF7, 1'b0);
        // offset wraps modulo eight words
        add_step(0, RD, FIXED, 16'h000A, 16'h0000, 16'hA502, 1'b0);
        // identity words ignore writes
        add_step(0, WR, FIXED, 16'h0000, 16'hFFFF, 16'h0000, 1'b0);
        add_step(1, WR, FIXED, 16'h0001, 16'h1234, 16'h0000, 1'b0);
        add_step(1, RD, FIXED, 16'h0000, 16'h0000, 16'h0002, 1'b0);
        add_step(0, RD, FIXED, 16'h0001, 16'h0000, 16'h0002, 1'b0);
        // gpio with random data, any offset
        add_step(0, WR, RAND,  16'h0100, 16'h0000, 16'h0000, 1'b0);
        add_step(1, RD, RAND,  16'h0100, 16'h0000, 16'h0000, 1'b0);
        add_step(1, WR, RAND,  16'h0137, 16'h0000, 16'h0000, 1'b0);
        add_step(0, RD, RAND,  16'h0100, 16'h0000, 16'h0000, 1'b0);
        // unmapped target fields
        add_step(0, RD, FIXED, 16'h0200, 16'h0000, 16'h0000, 1'b1);
        add_step(1, WR, FIXED, 16'h0300, 16'hBEEF, 16'h0000, 1'b1);
        add_step(0, WR, FIXED, 16'h8002, 16'h1111, 16'h0000, 1'b1);
        add_step(1, RD, FIXED, 16'hFF07, 16'h0000, 16'h0000, 1'b1);
        // nothing changed behind the error target
        add_step(0, RD, FIXED, 16'h0002, 16'h0000, 16'hA502, 1'b0);
        add_step(1, RD, RAND,  16'h0100, 16'h0000, 16'h0000, 1'b0);
    endfunction

    // target behavior from the address map
    function automatic void update_model(input addr_t addr, input data_t wdata);
        int field;
        int word;
        field = int'(addr[ADDR_WIDTH-1:TARGET_LSB]);
        word  = int'(addr[TARGET_LSB-1:0]) % REG_WORDS;
        if (field == TARGET_REGS && word >= 2) begin
            reg_model[word] = wdata;
        end else if (field == TARGET_GPIO) begin
            gpio_model = wdata[GPIO_PINS-1:0];
        end
    endfunction

    function automatic data_t expected_read(input addr_t addr);
        int field;
        int word;
        field = int'(addr[ADDR_WIDTH-1:TARGET_LSB]);
        word  = int'(addr[TARGET_LSB-1:0]) % REG_WORDS;
        if (field == TARGET_REGS) begin
            if (word == 0) begin
                return data_t'(MASTERS);
            end else if (word == 1) begin
                return data_t'(NUM_TARGETS);
            end
            return reg_model[word];
        end else if (field == TARGET_GPIO) begin
            return data_t'(gpio_model);
        end
        return '0;
    endfunction

    initial begin
        step_t e;
        data_t wdata;
        data_t rdata;
        data_t exp_rdata;
        data_t rd0;
        data_t rd1;
        logic  err;
        logic  er0;
        logic  er1;

        reset      = 1'b1;
        m_psel     = '0;
        m_penable  = '0;
        m_pwrite   = '0;
        m_paddr    = '0;
        m_pwdata   = '0;
        gpio_model = '0;
        for (int i = 0; i < REG_WORDS; i++) begin
            reg_model[i] = '0;
        end
        load_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_gpio("gpio", gpio, '0);

        for (int i = 0; i < stim.size(); i++) begin
            e     = stim[i];
            wdata = e.rnd ? lcg_next() : e.wdata;
            apb_transfer(e.master, e.write, e.addr, wdata, rdata, err);
            check_err($sformatf("m_pslverr[%0d]", e.master), err, e.exp_err);
            if (e.write) begin
                update_model(e.addr, wdata);
                check_gpio("gpio", gpio, gpio_model);
            end
            // error answers carry zero read data on writes too
            if (!e.write || e.exp_err) begin
                exp_rdata = e.rnd ? expected_read(e.addr) : e.exp_rdata;
                check_data($sformatf("m_prdata[%0d]", e.master), rdata, exp_rdata);
            end
        end

        // both masters request in the same cycle
        fork
            apb_transfer(0, RD, 16'h0003, '0, rd0, er0);
            apb_transfer(1, RD, 16'h0006, '0, rd1, er1);
        join
        check_data("m_prdata[0]", rd0, expected_read(16'h0003));
        check_err("m_pslverr[0]", er0, 1'b0);
        check_data("m_prdata[1]", rd1, expected_read(16'h0006));
        check_err("m_pslverr[1]", er1, 1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule
